/* audioPkg.sv */
// audio package
// I2S frame constants and the structs passed between capture blocks

package audioPkg;

	//////////////////////////////////////////////////////////////////////
	// frame constants
	//////////////////////////////////////////////////////////////////////

	localparam int prescalerWidth  = 9;  // low 8 bits count one 256 cycle frame
	localparam int slotsPerChannel = 32; // bck periods per lrck half
	localparam int firstDataSlot   = 1;  // msb one slot after lrck edge
	localparam int latchSlot       = 25; // right half, after last data bit
	localparam int sampleWidth     = 24; // adc resolution

	//////////////////////////////////////////////////////////////////////
	// structs
	//////////////////////////////////////////////////////////////////////

	// codec pins driven by the receiver
	typedef struct packed {
		logic bck;  // bit clock, clk/4
		logic lrck; // left/right clock, clk/256
		logic scki; // codec system clock
	} i2sPins;

	typedef struct packed {
		logic shiftStrobe;  // clk cycle ahead of a bck rise, data slots only
		logic rightChannel; // lrck high half
		logic frameStrobe;  // latch cycle
	} i2sTiming;

	typedef struct packed {
		logic [sampleWidth-1:0] left;
		logic [sampleWidth-1:0] right;
	} stereoSample;

endpackage

/* apbPkg.sv */
// APB package
// request and response structs plus the sample register map

package apbPkg;

	localparam int addrWidth = 4;
	localparam int dataWidth = 32;

	// host to slave
	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [addrWidth-1:0] paddr;
		logic [dataWidth-1:0] pwdata;
	} apbReq;

	// slave to host
	typedef struct packed {
		logic [dataWidth-1:0] prdata;
		logic pready;
		logic pslverr;
	} apbRsp;

	//////////////////////////////////////////////////////////////////////
	// register map, all read only
	//////////////////////////////////////////////////////////////////////

	localparam logic [addrWidth-1:0] regLeft       = 4'h0;
	localparam logic [addrWidth-1:0] regRight      = 4'h4;
	localparam logic [addrWidth-1:0] regStatus     = 4'h8;
	localparam logic [addrWidth-1:0] regFrameCount = 4'hC;

	// status register layout
	typedef struct packed {
		logic [dataWidth-3:0] reserved;
		logic overrun;   // bit 1, sample lost before status read
		logic newSample; // bit 0
	} statusWord;

endpackage

/* i2sClockGen.sv */
// I2S clock generator
// free-running frame prescaler decoded into codec clocks and capture strobes

module i2sClockGen
(
	input logic clk,
	input logic reset,
	output audioPkg::i2sPins pins,
	output audioPkg::i2sTiming timing
);
	import audioPkg::*;

	localparam int SlotBits = $clog2(slotsPerChannel); // 5, slot is prescaler[6:2]
	localparam logic [SlotBits-1:0] FirstSlot = SlotBits'(firstDataSlot);
	localparam logic [SlotBits-1:0] LastSlot  = SlotBits'(firstDataSlot + sampleWidth - 1);
	localparam logic [SlotBits-1:0] LatchSlot = SlotBits'(latchSlot);

	logic [prescalerWidth-1:0] prescaler;
	logic [SlotBits-1:0] slot; // bit slot inside the current half frame
	logic lrckBit;
	logic risePhase;           // bck rises at the end of this cycle
	logic sckiReg;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			prescaler <= '0;
			sckiReg <= 1'b0;
		end
		else
		begin
			prescaler <= prescaler + 1'b1;
			sckiReg <= prescaler[0]; // clk/2
		end
	end

	assign slot      = prescaler[SlotBits+1:2];
	assign lrckBit   = prescaler[SlotBits+2]; // bit 7
	assign risePhase = (prescaler[1:0] == 2'd1);

	assign pins.bck  = prescaler[1]; // 64 fs
	assign pins.lrck = lrckBit;      // fs, low for left
	assign pins.scki = sckiReg;

	// strobes let every downstream register run on clk
	assign timing.shiftStrobe  = risePhase && (slot >= FirstSlot) && (slot <= LastSlot);
	assign timing.rightChannel = lrckBit;
	assign timing.frameStrobe  = risePhase && lrckBit && (slot == LatchSlot);

endmodule

/* i2sDeserializer.sv */
// I2S deserializer
// left/right shift registers and the once-per-frame stereo latch

module i2sDeserializer
#(
	parameter int SampleWidth = audioPkg::sampleWidth
)
(
	input logic clk,
	input logic reset,
	input logic din,
	input audioPkg::i2sTiming timing,
	output audioPkg::stereoSample sample,
	output logic sampleValid
);
	import audioPkg::*;

	logic [SampleWidth-1:0] leftShift;  // msb arrives first
	logic [SampleWidth-1:0] rightShift;

	//////////////////////////////////////////////////////////////////////
	// capture
	//////////////////////////////////////////////////////////////////////

	// exactly SampleWidth strobes per half, so no bit count is needed
	always_ff @(posedge clk)
	begin
		if (timing.shiftStrobe)
		begin
			if (timing.rightChannel)
				rightShift <= {rightShift[SampleWidth-2:0], din};
			else
				leftShift <= {leftShift[SampleWidth-2:0], din};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// frame latch
	//////////////////////////////////////////////////////////////////////

	// both halves copied together, left and right always from one frame
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sample <= '0;
			sampleValid <= 1'b0;
		end
		else
		begin
			sampleValid <= timing.frameStrobe; // one cycle every 256
			if (timing.frameStrobe)
			begin
				sample.left <= sampleWidth'(leftShift);
				sample.right <= sampleWidth'(rightShift);
			end
		end
	end

endmodule

/* apbSampleRegs.sv */
// APB sample registers
// status flags, frame counter and zero wait state readout of the stereo sample

module apbSampleRegs
#(
	parameter int SampleWidth = audioPkg::sampleWidth
)
(
	input logic clk,
	input logic reset,
	input audioPkg::stereoSample sample,
	input logic sampleValid,
	input apbPkg::apbReq apbIn,
	output apbPkg::apbRsp apbOut
);
	import apbPkg::*;

	logic newSample;
	logic overrun;
	logic [dataWidth-1:0] frameCount; // latched frames since reset
	logic access;                     // access phase of any transfer
	logic readAccess;
	logic statusRead;                 // clears both flags
	logic addrHit;
	statusWord status;

	// sample msb copied into the upper bits
	function automatic logic [dataWidth-1:0] signExtend(input logic [SampleWidth-1:0] value);
		return {{(dataWidth - SampleWidth){value[SampleWidth-1]}}, value};
	endfunction

	assign access     = apbIn.psel && apbIn.penable;
	assign readAccess = access && !apbIn.pwrite;
	assign statusRead = readAccess && (apbIn.paddr == regStatus);
	assign addrHit    = apbIn.paddr inside {regLeft, regRight, regStatus, regFrameCount};

	//////////////////////////////////////////////////////////////////////
	// flags and counter
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			newSample <= 1'b0;
			overrun <= 1'b0;
		end
		else if (sampleValid)
		begin
			newSample <= 1'b1; // a fresh sample beats a same-cycle clear
			overrun <= (newSample || overrun) && !statusRead; // previous one never read
		end
		else if (statusRead)
		begin
			newSample <= 1'b0;
			overrun <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			frameCount <= '0;
		else if (sampleValid)
			frameCount <= frameCount + 1'b1; // wraps
	end

	assign status = '{reserved: '0, overrun: overrun, newSample: newSample};

	//////////////////////////////////////////////////////////////////////
	// read decode
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		apbOut.prdata = '0;
		apbOut.pready = 1'b1; // never any wait states
		apbOut.pslverr = access && (apbIn.pwrite || !addrHit); // nothing writable
		if (readAccess)
		begin
			case (apbIn.paddr)
				regLeft:       apbOut.prdata = signExtend(sample.left[SampleWidth-1:0]);
				regRight:      apbOut.prdata = signExtend(sample.right[SampleWidth-1:0]);
				regStatus:     apbOut.prdata = status;
				regFrameCount: apbOut.prdata = frameCount;
				default:       apbOut.prdata = '0; // unmapped, pslverr set
			endcase
		end
	end

endmodule

/* i2sCapture.sv */
// I2S capture top
// stereo receiver for a 24-bit ADC, clock master, samples read over APB

module i2sCapture
#(
	parameter int SampleWidth = audioPkg::sampleWidth
)
(
	input logic clk,
	input logic reset,
	input logic din,               // codec serial data
	output audioPkg::i2sPins pins, // bck, lrck, scki
	input apbPkg::apbReq apbIn,
	output apbPkg::apbRsp apbOut
);
	import audioPkg::*;

	i2sTiming timing;    // strobes from the prescaler
	stereoSample sample; // latched frame
	logic sampleValid;

	i2sClockGen clockGen
	(
		.clk(clk),
		.reset(reset),
		.pins(pins),
		.timing(timing)
	);

	i2sDeserializer #(.SampleWidth(SampleWidth)) deserializer
	(
		.clk(clk),
		.reset(reset),
		.din(din),
		.timing(timing),
		.sample(sample),
		.sampleValid(sampleValid)
	);

	// readable 2 cycles after the latch slot
	apbSampleRegs #(.SampleWidth(SampleWidth)) sampleRegs
	(
		.clk(clk),
		.reset(reset),
		.sample(sample),
		.sampleValid(sampleValid),
		.apbIn(apbIn),
		.apbOut(apbOut)
	);

endmodule

/* tbClock.sv */
// testbench clock and reset
// period 8, reset high for the first 8 rising edges

module tbClock
(
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial
	begin
		reset = 1'b1;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

/* i2sCapture_assert.sv */
// I2S capture assertions
// clock pin and APB timing rules, bound into the top level

module i2sCaptureAssert
(
	input logic clk,
	input logic reset,
	input logic sampleValid,
	input audioPkg::i2sPins pins,
	input apbPkg::apbRsp apbOut
);

	// zero wait state slave
	readyHigh: assert property (@(posedge clk) disable iff (reset) apbOut.pready)
		else $error("pready went low");

	// one latch per frame, never back to back
	validPulse: assert property (@(posedge clk) disable iff (reset) sampleValid |=> !sampleValid)
		else $error("sampleValid high on two cycles in a row");

	// lrck moves with a bck fall only
	lrckOnBckLow: assert property (@(posedge clk) disable iff (reset)
		(pins.lrck != $past(pins.lrck)) |-> !pins.bck)
		else $error("lrck changed while bck was high");

endmodule

bind i2sCapture i2sCaptureAssert checks
(
	.clk(clk),
	.reset(reset),
	.sampleValid(sampleValid),
	.pins(pins),
	.apbOut(apbOut)
);

/* i2sCaptureTb.sv */
// I2S capture testbench
// codec model, APB host tasks and directed tests of the receiver

module i2sCaptureTb;
	import audioPkg::*;
	import apbPkg::*;

	logic clk;
	logic reset;
	logic din = 1'b0;
	i2sPins pins;
	apbReq apbIn = '0;
	apbRsp apbOut;
	integer seed = 32'hda76;
	int checkCount = 0;
	int errorCount = 0;
	int testErrors = 0;         // errorCount when the running test began
	stereoSample nextPair = '0; // sent from the next left half on
	stereoSample txPair;
	logic [sampleWidth-1:0] txShift;
	logic bckLast;
	logic lrckAtFall;           // lrck seen at the previous bck fall
	int slotNum;
	int framesSent;             // left halves begun by the codec model

	tbClock clockGen (.clk(clk), .reset(reset));
	i2sCapture #(.SampleWidth(sampleWidth)) UUT (.clk, .reset, .din, .pins, .apbIn, .apbOut);

	//////////////////////////////////////////////////////////////////////
	// codec model
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin
		if (reset)
		begin
			din <= 1'b0;
			bckLast <= 1'b0;
			framesSent <= 0;
			lrckAtFall = 1'b1; // first fall opens a left half
			slotNum = 0;
		end
		else
		begin
			bckLast <= pins.bck;
			if (bckLast && pins.bck) // bck falls at this edge
			begin
				if (pins.lrck != lrckAtFall)
				begin
					slotNum = firstDataSlot; // one slot after the lrck edge
					if (!pins.lrck)
					begin
						txPair = nextPair;
						framesSent <= framesSent + 1;
					end
					txShift = pins.lrck ? txPair.right : txPair.left;
				end
				else
					slotNum = slotNum + 1;
				lrckAtFall = pins.lrck;
				if (slotNum < firstDataSlot + sampleWidth)
				begin
					din <= txShift[sampleWidth-1]; // msb first
					txShift = txShift << 1;
				end
				else
					din <= 1'b0; // idle slots
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// compare tasks and reporting
	//////////////////////////////////////////////////////////////////////

	task automatic checkWord(string what, logic [dataWidth-1:0] got, logic [dataWidth-1:0] exp);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("MISMATCH %0t: %s expected %h got %h", $time, what, exp, got);
		end
	endtask

	task automatic checkSample(string what, stereoSample got, stereoSample exp);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("MISMATCH %0t: %s expected %h got %h", $time, what, exp, got);
		end
	endtask

	task automatic checkRsp(string what, apbRsp got, apbRsp exp);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("MISMATCH %0t: %s expected %h got %h", $time, what, exp, got);
		end
	endtask

	task automatic checkPins(string what, i2sPins got, i2sPins exp);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("MISMATCH %0t: %s expected %b got %b", $time, what, exp, got);
		end
	endtask

	task automatic abortRun(string why);
		$display("timeout: %s", why);
		$display("Regression failed");
		$finish;
	endtask

	task automatic endTest(string name);
		$display("%s: %0d errors", name, errorCount - testErrors);
		testErrors = errorCount;
	endtask

	// 24 bit sample widened to a register word
	function automatic logic [dataWidth-1:0] withSignBits(logic signed [sampleWidth-1:0] value);
		return dataWidth'(value); // signed source, upper bits follow the msb
	endfunction

	//////////////////////////////////////////////////////////////////////
	// APB host and waits
	//////////////////////////////////////////////////////////////////////

	task automatic apbTransfer(logic write, logic [addrWidth-1:0] addr, output apbRsp rsp);
		@(posedge clk);
		apbIn <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: '1};
		@(posedge clk);
		apbIn.penable <= 1'b1;
		@(negedge clk);
		rsp = apbOut; // mid access cycle
		@(posedge clk);
		apbIn <= '0;
	endtask

	task automatic apbRead(logic [addrWidth-1:0] addr, output apbRsp rsp);
		apbTransfer(1'b0, addr, rsp);
	endtask

	task automatic apbWrite(logic [addrWidth-1:0] addr, output apbRsp rsp);
		apbTransfer(1'b1, addr, rsp);
	endtask

	// polls status until newSample is set, that read clears it
	task automatic waitSampleFrame(output logic [dataWidth-1:0] status);
		apbRsp rsp;
		for (int i = 0; i < 150; i++)
		begin
			apbRead(regStatus, rsp);
			status = rsp.prdata;
			if (status[0])
				return;
		end
		abortRun("newSample flag never set");
	endtask

	task automatic waitFrames(int count);
		int target;
		target = framesSent + count;
		for (int i = 0; i < 300 * count; i++)
		begin
			@(posedge clk);
			if (framesSent >= target)
				return;
		end
		abortRun("codec model saw no new frame");
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic resetState();
		apbRsp rsp;
		i2sPins expected;
		for (int i = 0; i < 20; i++)
		begin
			@(negedge clk);
			if (!reset)
				break;
			checkPins("pins in reset", pins, '0);
		end
		if (reset)
			abortRun("reset never released");
		// prescaler counts up from 0 at the first edge after reset
		for (int k = 1; k < 140; k++)
		begin
			@(negedge clk);
			expected.bck = k[1];   // clk/4
			expected.lrck = k[7];  // clk/256
			expected.scki = ~k[0]; // clk/2, bit 0 one cycle late
			checkPins("pins after reset", pins, expected);
		end
		apbRead(regStatus, rsp);
		checkWord("status after reset", rsp.prdata, '0);
		apbRead(regFrameCount, rsp);
		checkWord("frame count after reset", rsp.prdata, '0);
		apbRead(regLeft, rsp);
		checkWord("left after reset", rsp.prdata, '0);
		apbRead(regRight, rsp);
		checkWord("right after reset", rsp.prdata, '0);
		endTest("reset");
	endtask

	task automatic capturePairs();
		apbRsp rsp;
		stereoSample pair;
		stereoSample got;
		logic [dataWidth-1:0] status;
		for (int n = 0; n < 4; n++)
		begin
			pair.left = sampleWidth'($random(seed));
			pair.right = sampleWidth'($random(seed));
			@(negedge clk);
			nextPair = pair;         // clear of the model's edge
			waitFrames(1);           // pair now on the wire
			apbRead(regStatus, rsp); // drop the older frame's flag
			waitSampleFrame(status);
			apbRead(regLeft, rsp);
			got.left = rsp.prdata[sampleWidth-1:0];
			checkWord("left word", rsp.prdata, withSignBits(pair.left));
			apbRead(regRight, rsp);
			got.right = rsp.prdata[sampleWidth-1:0];
			checkWord("right word", rsp.prdata, withSignBits(pair.right));
			checkSample("stereo pair", got, pair);
		end
		endTest("capture");
	endtask

	task automatic statusClear();
		apbRsp rsp;
		logic [dataWidth-1:0] status;
		waitFrames(1);
		apbRead(regStatus, rsp);
		waitSampleFrame(status);
		checkWord("status with new sample", status, 32'h1);
		apbRead(regStatus, rsp);
		checkWord("status after clear", rsp.prdata, 32'h0);
		endTest("status clear");
	endtask

	task automatic overrunFlags();
		apbRsp rsp;
		apbRead(regStatus, rsp);
		waitFrames(3); // at least two latches unread
		apbRead(regStatus, rsp);
		checkWord("status after missed frames", rsp.prdata, 32'h3);
		apbRead(regStatus, rsp);
		checkWord("status after overrun read", rsp.prdata, 32'h0);
		endTest("overrun");
	endtask

	task automatic busErrors();
		apbRsp rsp;
		apbRsp expected;
		waitFrames(1);
		apbRead(regStatus, rsp); // next latch is half a frame away
		expected = '{prdata: '0, pready: 1'b1, pslverr: 1'b1};
		for (int a = 0; a < 16; a += 4)
		begin
			apbWrite(addrWidth'(a), rsp);
			checkRsp("write", rsp, expected);
		end
		apbRead(4'h1, rsp);
		checkRsp("read of 0x1", rsp, expected);
		apbRead(4'h3, rsp);
		checkRsp("read of 0x3", rsp, expected);
		expected = '{prdata: withSignBits(nextPair.left), pready: 1'b1, pslverr: 1'b0};
		apbRead(regLeft, rsp);
		checkRsp("left read", rsp, expected);
		expected.prdata = withSignBits(nextPair.right);
		apbRead(regRight, rsp);
		checkRsp("right read", rsp, expected);
		expected.prdata = '0;
		apbRead(regStatus, rsp);
		checkRsp("status read", rsp, expected);
		endTest("bus errors");
	endtask

	task automatic frameCounting();
		apbRsp rsp;
		logic [dataWidth-1:0] status;
		logic [dataWidth-1:0] firstCount;
		int firstSent;
		waitFrames(1);
		apbRead(regStatus, rsp);
		waitSampleFrame(status);
		apbRead(regFrameCount, rsp);
		firstCount = rsp.prdata;
		firstSent = framesSent;
		waitFrames(3);
		apbRead(regStatus, rsp);
		waitSampleFrame(status); // same phase as the first read
		apbRead(regFrameCount, rsp);
		checkWord("frame count step", rsp.prdata - firstCount, dataWidth'(framesSent - firstSent));
		endTest("frame count");
	endtask

	initial
	begin
		resetState();
		capturePairs();
		statusClear();
		overrunFlags();
		busErrors();
		frameCounting();
		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* project.f */
audioPkg.sv
apbPkg.sv
i2sClockGen.sv
i2sDeserializer.sv
apbSampleRegs.sv
i2sCapture.sv
tbClock.sv
i2sCapture_assert.sv
i2sCaptureTb.sv

/* Makefile */
# I2S capture regression with Verilator

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the regression"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --top-module i2sCaptureTb -Mdir obj_dir -f project.f
	./obj_dir/Vi2sCaptureTb > sim.log; cat sim.log
	@if grep -q "Regression failed" sim.log; then echo "test FAILED"; exit 1; fi
	@grep -q "Regression passed" sim.log || (echo "test did not finish"; exit 1)

clean:
	rm -rf obj_dir sim.log
